/* umi_mem_pkg.sv */
package umi_mem_pkg;

    // opcodes understood by the endpoint
    // write-normal doubles as the read response opcode
    localparam logic [7:0] UMI_OP_WRITE = 8'h01;
    localparam logic [7:0] UMI_OP_READ  = 8'h08;

    localparam int unsigned UMI_PACKET_WIDTH = 256;

    // command class after decode
    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_OTHER = 2'd2
    } umi_cmd_e;

    // 256-bit link packet
    // fields run MSB first, so opcode sits in the low byte
    typedef struct packed {
        logic [95:0] data;
        logic [63:0] srcaddr;
        logic [63:0] dstaddr;
        logic        burst;
        logic [18:0] user;
        logic [3:0]  size;
        logic [7:0]  opcode;
    } umi_packet_t;

    // request as seen by the memory core
    typedef struct packed {
        umi_cmd_e    cmd;
        logic [63:0] dstaddr;
        logic [63:0] srcaddr;
        logic [63:0] data;
    } umi_req_t;

    // size code is log2 of the word size in bytes
    function automatic logic [3:0] umi_size_of(input int unsigned width);
        int unsigned bytes;
        bytes = width / 8;
        return 4'($clog2(bytes));
    endfunction

endpackage

/* umi_rx_decode.sv */
module umi_rx_decode
    import umi_mem_pkg::*;
(
    input  umi_packet_t rx_packet,
    output umi_req_t    rx_req
);

    umi_cmd_e cmd;

    // classify opcode
    // anything not a plain read or write is dropped by the core
    always_comb begin
        case (rx_packet.opcode)
            UMI_OP_READ: begin
                cmd = CMD_READ;
            end
            UMI_OP_WRITE: begin
                cmd = CMD_WRITE;
            end
            default: begin
                cmd = CMD_OTHER;
            end
        endcase
    end

    // addresses pass straight through, only low data word is kept
    always_comb begin
        rx_req.cmd     = cmd;
        rx_req.dstaddr = rx_packet.dstaddr;
        rx_req.srcaddr = rx_packet.srcaddr;
        rx_req.data    = rx_packet.data[63:0];
    end

    // bursts are not supported on reads or writes
    always_comb begin
        if (cmd != CMD_OTHER) begin
            burst_zero_chk : assert #0 (rx_packet.burst == 1'b0)
                else $error("burst set on read or write request");
        end
    end

endmodule

/* umi_mem_core.sv */
module umi_mem_core
    import umi_mem_pkg::*;
#(
    parameter int unsigned ADDR_WIDTH = 8,
    parameter int unsigned DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  umi_req_t              rx_req,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    input  logic                  tx_busy,
    output logic                  rsp_load,
    output logic [63:0]           rsp_dstaddr,
    output logic [DATA_WIDTH-1:0] rsp_data
);

    localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

    // only 32 and 64 bit words are supported
    if (DATA_WIDTH != 32 && DATA_WIDTH != 64) begin : g_width_chk
        $error("DATA_WIDTH must be 32 or 64");
    end

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic [ADDR_WIDTH-1:0] addr;
    logic                  rx_pending;
    logic                  do_write;
    logic                  do_read;
    logic                  do_drop;
    logic                  do_accept;

    // low address bits select the word and upper bits alias
    assign addr = rx_req.dstaddr[ADDR_WIDTH-1:0];

    // request waiting and not already in its handshake cycle
    assign rx_pending = rx_valid && !rx_ready;

    assign do_write  = rx_pending && (rx_req.cmd == CMD_WRITE);
    assign do_drop   = rx_pending && (rx_req.cmd == CMD_OTHER);
    // a read needs the response slot free
    assign do_read   = rx_pending && (rx_req.cmd == CMD_READ) && !tx_busy;
    assign do_accept = do_write || do_read || do_drop;

    // one-cycle ready pulse with the transfer on the following edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_ready <= 1'b0;
            rsp_load <= 1'b0;
        end else begin
            rx_ready <= do_accept;
            rsp_load <= do_read;
        end
    end

    // storage and response payload
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[addr] <= rx_req.data[DATA_WIDTH-1:0];
        end
        if (do_read) begin
            rsp_data    <= mem[addr];
            // response goes back to the requester
            rsp_dstaddr <= rx_req.srcaddr;
        end
    end

    // request was acted on one edge early, so it must sit still through the pulse
    req_hold_chk : assert property (
        @(posedge clk) disable iff (!arst_n)
        rx_ready |-> (rx_valid && $stable(rx_req))
    ) else $error("request dropped or changed during rx_ready");

    // encoder must be idle whenever a response is handed over
    rsp_slot_chk : assert property (
        @(posedge clk) disable iff (!arst_n)
        rsp_load |-> !tx_busy
    ) else $error("response loaded while transmitter busy");

endmodule

/* umi_tx_encode.sv */
module umi_tx_encode
    import umi_mem_pkg::*;
#(
    parameter int unsigned DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  rsp_load,
    input  logic [63:0]           rsp_dstaddr,
    input  logic [DATA_WIDTH-1:0] rsp_data,
    output umi_packet_t           tx_packet,
    output logic                  tx_valid,
    output logic                  tx_busy,
    input  logic                  tx_ready
);

    localparam logic [3:0] RSP_SIZE = umi_size_of(DATA_WIDTH);

    umi_packet_t rsp_packet;

    // read response is sent as a write-normal
    always_comb begin
        rsp_packet         = '0;
        rsp_packet.opcode  = UMI_OP_WRITE;
        rsp_packet.size    = RSP_SIZE;
        rsp_packet.dstaddr = rsp_dstaddr;
        rsp_packet.data    = 96'(rsp_data);
    end

    // valid holds until the transfer edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_valid <= 1'b0;
        end else if (rsp_load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            tx_packet <= rsp_packet;
        end
    end

    // the core only issues reads while this is low
    assign tx_busy = tx_valid;

    tx_hold_chk : assert property (
        @(posedge clk) disable iff (!arst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_packet))
    ) else $error("tx_packet changed while waiting for tx_ready");

endmodule

/* umi_mem.sv */
module umi_mem
    import umi_mem_pkg::*;
#(
    parameter int unsigned ADDR_WIDTH = 8,
    parameter int unsigned DATA_WIDTH = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  umi_packet_t rx_packet,
    input  logic        rx_valid,
    output logic        rx_ready,
    output umi_packet_t tx_packet,
    output logic        tx_valid,
    input  logic        tx_ready
);

    umi_req_t              rx_req;
    logic                  tx_busy;
    logic                  rsp_load;
    logic [63:0]           rsp_dstaddr;
    logic [DATA_WIDTH-1:0] rsp_data;

    umi_rx_decode u_rx_decode (
        .rx_packet (rx_packet),
        .rx_req    (rx_req)
    );

    umi_mem_core #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mem_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_req      (rx_req),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .tx_busy     (tx_busy),
        .rsp_load    (rsp_load),
        .rsp_dstaddr (rsp_dstaddr),
        .rsp_data    (rsp_data)
    );

    umi_tx_encode #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tx_encode (
        .clk         (clk),
        .arst_n      (arst_n),
        .rsp_load    (rsp_load),
        .rsp_dstaddr (rsp_dstaddr),
        .rsp_data    (rsp_data),
        .tx_packet   (tx_packet),
        .tx_valid    (tx_valid),
        .tx_busy     (tx_busy),
        .tx_ready    (tx_ready)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int unsigned PERIOD       = 100,
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* umi_mem_tb_util.svh */
`ifndef UMI_MEM_TB_UTIL_SVH
`define UMI_MEM_TB_UTIL_SVH

// xorshift32 step on the shared generator state
function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [63:0] random64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi, lo};
endfunction

// shadow word, upper address bits alias
function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [63:0] addr);
    return shadow[addr[ADDR_WIDTH-1:0]];
endfunction

function automatic umi_packet_t make_request(input logic [7:0] opcode, input logic [63:0] dst,
                                             input logic [63:0] src, input logic [63:0] data);
    umi_packet_t p;
    p         = '0;
    p.opcode  = opcode;
    p.size    = RSP_SIZE;
    p.dstaddr = dst;
    p.srcaddr = src;
    p.data    = 96'(data);
    return p;
endfunction

// read response goes back to the requester as a write-normal
function automatic umi_packet_t make_response(input logic [63:0] dst,
                                              input logic [DATA_WIDTH-1:0] word);
    umi_packet_t p;
    p         = '0;
    p.opcode  = UMI_OP_WRITE;
    p.size    = RSP_SIZE;
    p.dstaddr = dst;
    p.data    = 96'(word);
    return p;
endfunction

task automatic report_failure();
    $display("Testbench failed");
    $fatal(1);
endtask

task automatic check_packet(input string name, input umi_packet_t exp, input umi_packet_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        report_failure();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected %b actual %b", name, exp, act);
        report_failure();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("ERR %s expected %0d actual %0d", name, exp, act);
        report_failure();
    end
endtask

`endif

/* umi_mem_tb.sv */
module umi_mem_tb
    import umi_mem_pkg::*;
();

    localparam int unsigned ADDR_WIDTH   = 8;
    localparam int unsigned DATA_WIDTH   = 32;
    localparam int          NUM_REQUESTS = 230;
    localparam int          CYCLE_LIMIT  = 20 * NUM_REQUESTS + 200;
    // 4-byte words give size 2, 8-byte words size 3
    localparam logic [3:0]  RSP_SIZE     = (DATA_WIDTH == 64) ? 4'd3 : 4'd2;

    logic        clk;
    logic        arst_n;
    umi_packet_t rx_packet;
    logic        rx_valid;
    logic        rx_ready;
    umi_packet_t tx_packet;
    logic        tx_valid;
    logic        tx_ready;

    logic [31:0]                  rng_state  = 32'hb986c55f;
    logic [DATA_WIDTH-1:0]        shadow [2 ** ADDR_WIDTH];
    logic [2 ** ADDR_WIDTH - 1:0] written    = '0;
    umi_packet_t                  expected_q [$];
    string                        cur_test   = "reset";
    logic                         rand_ready = 1'b0;
    int                           exp_count  = 0;
    int                           rsp_count  = 0;
    int                           cycles     = 0;
    logic [63:0]                  test_addr [8];

    `include "umi_mem_tb_util.svh"

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    umi_mem #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_packet (rx_packet),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .tx_packet (tx_packet),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    task automatic drive_request(input umi_packet_t pkt);
        rx_packet = pkt;
        rx_valid  = 1'b1;
    endtask

    task automatic wait_transfer();
        logic [31:0] rnd;
        @(negedge clk);
        while (!rx_ready) begin
            if (rand_ready) begin
                rnd      = next_random();
                tx_ready = rnd[9];
            end
            @(negedge clk);
        end
        // transfer lands on the rising edge just passed
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_request(input umi_packet_t pkt);
        drive_request(pkt);
        wait_transfer();
    endtask

    task automatic drain_responses();
        tx_ready = 1'b1;
        while (expected_q.size() != 0 || tx_valid) begin
            @(negedge clk);
        end
    endtask

    // shadow memory follows rx transfers and responses are checked in order
    always @(posedge clk) begin
        if (arst_n && rx_valid && rx_ready) begin
            if (rx_packet.opcode == UMI_OP_WRITE) begin
                shadow[rx_packet.dstaddr[ADDR_WIDTH-1:0]]  = rx_packet.data[DATA_WIDTH-1:0];
                written[rx_packet.dstaddr[ADDR_WIDTH-1:0]] = 1'b1;
            end else if (rx_packet.opcode == UMI_OP_READ) begin
                expected_q.push_back(make_response(rx_packet.srcaddr,
                                                   expected_read(rx_packet.dstaddr)));
                exp_count++;
            end
        end
        if (arst_n && tx_valid && tx_ready) begin
            rsp_count++;
            if (expected_q.size() == 0) begin
                $display("response seen with no read outstanding in test %s", cur_test);
                report_failure();
            end else begin
                check_packet(cur_test, expected_q.pop_front(), tx_packet);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        logic [63:0] addr;
        rx_packet = '0;
        rx_valid  = 1'b0;
        tx_ready  = 1'b0;
        @(posedge arst_n);
        @(negedge clk);
        check_bit("reset rx_ready", 1'b0, rx_ready);
        check_bit("reset tx_valid", 1'b0, tx_valid);

        cur_test = "write read";
        tx_ready = 1'b1;
        for (int i = 0; i < 8; i++) begin
            test_addr[i] = 64'(8'(i * 37 + 5));
            send_request(make_request(UMI_OP_WRITE, test_addr[i], 64'h0, random64()));
        end
        for (int i = 0; i < 8; i++) begin
            send_request(make_request(UMI_OP_READ, test_addr[i], random64(), 64'h0));
        end
        drain_responses();

        // read back through a different upper address
        cur_test = "aliasing";
        for (int i = 0; i < 4; i++) begin
            addr = random64();
            send_request(make_request(UMI_OP_WRITE, addr, 64'h0, random64()));
            send_request(make_request(UMI_OP_READ, {~addr[63:8], addr[7:0]}, random64(), 64'h0));
        end
        drain_responses();

        cur_test = "backpressure";
        tx_ready = 1'b0;
        addr     = random64();
        send_request(make_request(UMI_OP_READ, test_addr[0], random64(), 64'h0));
        send_request(make_request(UMI_OP_WRITE, addr, 64'h0, random64()));
        check_bit("backpressure tx_valid held", 1'b1, tx_valid);
        drive_request(make_request(UMI_OP_READ, addr, random64(), 64'h0));
        repeat (6) begin
            @(negedge clk);
            check_bit("backpressure rx_ready", 1'b0, rx_ready);
        end
        tx_ready = 1'b1;
        wait_transfer();
        drain_responses();

        cur_test = "other opcode";
        send_request(make_request(8'h00, random64(), random64(), random64()));
        send_request(make_request(8'h55, random64(), random64(), random64()));
        send_request(make_request(8'hff, random64(), random64(), random64()));
        repeat (10) @(negedge clk);
        check_bit("other opcode tx_valid", 1'b0, tx_valid);
        check_count("other opcode responses", exp_count, rsp_count);

        // reads only hit words that have been written
        cur_test   = "random mix";
        rand_ready = 1'b1;
        for (int i = 0; i < 200; i++) begin
            addr = random64();
            rnd  = next_random();
            if (rnd[0] && written[addr[ADDR_WIDTH-1:0]]) begin
                send_request(make_request(UMI_OP_READ, addr, random64(), 64'h0));
            end else begin
                send_request(make_request(UMI_OP_WRITE, addr, 64'h0, random64()));
            end
        end
        rand_ready = 1'b0;
        drain_responses();

        if (rsp_count != exp_count) begin
            $display("ERR total responses expected %0d actual %0d", exp_count, rsp_count);
            report_failure();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* umi_mem.f */
+incdir+.
umi_mem_pkg.sv
umi_rx_decode.sv
umi_mem_core.sv
umi_tx_encode.sv
umi_mem.sv
tb_clock_gen.sv
umi_mem_tb.sv

/* Makefile */
TOP := umi_mem_tb
RTL := umi_mem_pkg.sv umi_rx_decode.sv umi_mem_core.sv umi_tx_encode.sv umi_mem.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f umi_mem.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "Testbench failed" sim.log
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --top-module umi_mem $(RTL)

clean:
	rm -rf obj_dir sim.log
